//--- hw/ahb_lite_pkg.sv
// AHB-Lite bus widths shared by the SRAM subsystem
// HTRANS, HSIZE and HRESP encodings
// Address map of the two SRAM regions

package ahb_lite_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One enable per byte lane
  localparam int BE_W   = DATA_W / 8;

  //////////////////////////////////////////////////
  // Transfer encodings
  //////////////////////////////////////////////////

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Only the sizes a 32-bit bus can carry
  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // Each region spans 2**REGION_BITS bytes
  localparam int REGION_BITS = 12;
  localparam logic [ADDR_W-1:0] SLV0_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] SLV1_BASE = 32'h0000_1000;

endpackage

//--- hw/ram_1r1w.sv
// One-read, one-write word memory
// Byte-lane writes, read port sampled on the clock edge
// Full-word write to read forwarding

`timescale 1ns/1ns

module ram_1r1w #(
  parameter int MEM_DEPTH = 256,
  parameter int ABITS     = 8
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // Write port
  input  logic [ABITS-1:0]                waddr,
  input  logic                            we,
  input  logic [ahb_lite_pkg::BE_W-1:0]   be,
  input  logic [ahb_lite_pkg::DATA_W-1:0] din,
  // Read port
  input  logic [ABITS-1:0]                raddr,
  output logic [ahb_lite_pkg::DATA_W-1:0] dout
);

  import ahb_lite_pkg::*;

  logic [DATA_W-1:0] mem [MEM_DEPTH];
  logic              full_fwd;

  // Same word written on all lanes while being read
  assign full_fwd = we & (&be) & (waddr == raddr);

  // Array write, one byte lane at a time
  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < BE_W; i++) begin
        if (be[i]) begin
          mem[waddr][8*i +: 8] <= din[8*i +: 8];
        end
      end
    end
  end

  // Read address taken at the edge, array is read-first
  // A partial write collision returns the old word
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dout <= '0;
    end else if (full_fwd) begin
      dout <= din;
    end else begin
      dout <= mem[raddr];
    end
  end

endmodule

//--- hw/ahb_sram_slave.sv
// AHB-Lite SRAM slave on a one-read, one-write memory
// Late write from registered address, byte enables and HWDATA
// Read/write contention stall, optional registered read path

`timescale 1ns/1ns

module ahb_sram_slave #(
  parameter int MEM_DEPTH = 256,
  parameter bit REG_OUT   = 1'b0
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic                            HSEL,
  input  logic [ahb_lite_pkg::ADDR_W-1:0] HADDR,
  input  logic [ahb_lite_pkg::DATA_W-1:0] HWDATA,
  input  logic                            HWRITE,
  input  logic [2:0]                      HSIZE,
  input  logic [1:0]                      HTRANS,
  input  logic                            HREADY,
  output logic [ahb_lite_pkg::DATA_W-1:0] HRDATA,
  output logic                            HREADYOUT,
  output logic                            HRESP
);

  import ahb_lite_pkg::*;

  localparam int ABITS = $clog2(MEM_DEPTH);
  // Byte offset bits below the word address
  localparam int LSB   = $clog2(BE_W);

  logic              trans_active;
  logic              we;
  logic [BE_W-1:0]   be;
  logic [ABITS-1:0]  waddr;
  logic [ABITS-1:0]  haddr_word;
  logic [ABITS-1:0]  raddr;
  logic              contention;
  logic              ready;
  logic [DATA_W-1:0] dout;

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  function automatic logic [BE_W-1:0] gen_be(input logic [2:0]     hsize,
                                             input logic [LSB-1:0] offset);
    logic [BE_W-1:0] mask;
    case (hsize)
      HSIZE_BYTE:  mask = BE_W'(1) << offset;
      // Halfwords sit on even lanes only
      HSIZE_HWORD: mask = BE_W'(3) << {offset[1], 1'b0};
      HSIZE_WORD:  mask = '1;
      // Sizes wider than the bus touch no lane
      default:     mask = '0;
    endcase
    return mask;
  endfunction

  //////////////////////////////////////////////////
  // Address phase capture
  //////////////////////////////////////////////////

  assign trans_active = (HTRANS == HTRANS_NONSEQ) | (HTRANS == HTRANS_SEQ);
  assign haddr_word   = HADDR[LSB +: ABITS];

  // Write enable lives for one data phase only
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we <= 1'b0;
    end else if (HREADY) begin
      we <= HSEL & HWRITE & trans_active;
    end else begin
      we <= 1'b0;
    end
  end

  // Data phase address and lanes, used for writes and stalled reads
  always_ff @(posedge HCLK) begin
    if (HREADY) begin
      be    <= gen_be(HSIZE, HADDR[LSB-1:0]);
      waddr <= haddr_word;
    end
  end

  //////////////////////////////////////////////////
  // Contention and memory
  //////////////////////////////////////////////////

  // New read hits the word the pending write stores this cycle
  assign contention = we & (waddr == haddr_word) &
                      HSEL & HREADY & ~HWRITE & trans_active;

  // Full words are forwarded by the RAM, partial ones stall a cycle
  assign ready = ~(contention & ~(&be));

  // While stalled, keep reading the word of the current data phase
  assign raddr = HREADY ? haddr_word : waddr;

  ram_1r1w #(
    .MEM_DEPTH (MEM_DEPTH),
    .ABITS     (ABITS)
  ) u_ram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .waddr   (waddr),
    .we      (we),
    .be      (be),
    .din     (HWDATA),
    .raddr   (raddr),
    .dout    (dout)
  );

  // No error cases in an SRAM
  assign HRESP = HRESP_OKAY;

  //////////////////////////////////////////////////
  // Read response
  //////////////////////////////////////////////////

  if (REG_OUT == 1'b0) begin : g_comb_rd
    always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
        HREADYOUT <= 1'b1;
      end else begin
        HREADYOUT <= ready;
      end
    end

    assign HRDATA = dout;
  end else begin : g_reg_rd
    logic              rd_start;
    logic [BE_W-1:0]   fwd_be;
    logic [DATA_W-1:0] fwd_data;

    // SEQ reads wait too, the output register is never stale
    assign rd_start = HSEL & HREADY & ~HWRITE & trans_active;

    always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
        HREADYOUT <= 1'b1;
        fwd_be    <= '0;
      end else begin
        HREADYOUT <= ~rd_start;
        // Lanes the colliding write put in after the RAM read
        fwd_be    <= contention ? be : '0;
      end
    end

    always_ff @(posedge HCLK) begin
      if (contention) begin
        fwd_data <= HWDATA;
      end
      // Load at the end of the wait state, merging colliding lanes
      if (!HREADYOUT) begin
        for (int i = 0; i < BE_W; i++) begin
          HRDATA[8*i +: 8] <= fwd_be[i] ? fwd_data[8*i +: 8] : dout[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- hw/ahb_addr_decoder.sv
// AHB-Lite address decoder for two SRAM regions
// Data phase response multiplexer
// Default slave giving the two-cycle ERROR response

`timescale 1ns/1ns

module ahb_addr_decoder (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ahb_lite_pkg::ADDR_W-1:0] HADDR,
  input  logic [1:0]                      HTRANS,
  input  logic                            HREADY,
  input  logic                            hreadyout0,
  input  logic                            hreadyout1,
  input  logic                            hresp0,
  input  logic                            hresp1,
  input  logic [ahb_lite_pkg::DATA_W-1:0] hrdata0,
  input  logic [ahb_lite_pkg::DATA_W-1:0] hrdata1,
  output logic                            hsel0,
  output logic                            hsel1,
  output logic                            hreadyout,
  output logic                            hresp,
  output logic [ahb_lite_pkg::DATA_W-1:0] hrdata
);

  import ahb_lite_pkg::*;

  logic trans_active;
  logic unmapped;
  // Data phase owner
  logic sel0_q;
  logic sel1_q;
  // Default slave, first and second ERROR cycle
  logic err_first;
  logic err_second;

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////

  // Compare only the bits above the region size
  assign hsel0 = HADDR[ADDR_W-1:REGION_BITS] == SLV0_BASE[ADDR_W-1:REGION_BITS];
  assign hsel1 = HADDR[ADDR_W-1:REGION_BITS] == SLV1_BASE[ADDR_W-1:REGION_BITS];

  assign trans_active = (HTRANS == HTRANS_NONSEQ) | (HTRANS == HTRANS_SEQ);
  assign unmapped     = trans_active & ~hsel0 & ~hsel1;

  //////////////////////////////////////////////////
  // Data phase state
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel0_q     <= 1'b0;
      sel1_q     <= 1'b0;
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      if (HREADY) begin
        sel0_q <= hsel0;
        sel1_q <= hsel1;
      end
      // ERROR with HREADY low, then ERROR with HREADY high
      err_first  <= HREADY & unmapped;
      err_second <= err_first;
    end
  end

  //////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////

  always_comb begin
    hreadyout = 1'b1;
    hresp     = HRESP_OKAY;
    hrdata    = '0;
    if (err_first) begin
      hreadyout = 1'b0;
      hresp     = HRESP_ERROR;
    end else if (err_second) begin
      hresp     = HRESP_ERROR;
    end else if (sel0_q) begin
      hreadyout = hreadyout0;
      hresp     = hresp0;
      hrdata    = hrdata0;
    end else if (sel1_q) begin
      hreadyout = hreadyout1;
      hresp     = hresp1;
      hrdata    = hrdata1;
    end
  end

endmodule

//--- hw/ahb_sram_subsystem.sv
// AHB-Lite SRAM subsystem top level
// Decoder with default slave, SRAM slave 0 unregistered,
// SRAM slave 1 with registered read data

`timescale 1ns/1ns

module ahb_sram_subsystem #(
  parameter int MEM_DEPTH = 256
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ahb_lite_pkg::ADDR_W-1:0] HADDR,
  input  logic [1:0]                      HTRANS,
  input  logic                            HWRITE,
  input  logic [2:0]                      HSIZE,
  input  logic [ahb_lite_pkg::DATA_W-1:0] HWDATA,
  output logic [ahb_lite_pkg::DATA_W-1:0] HRDATA,
  output logic                            HREADY,
  output logic                            HRESP
);

  import ahb_lite_pkg::*;

  logic              hsel0;
  logic              hsel1;
  logic              hreadyout0;
  logic              hreadyout1;
  logic              hresp0;
  logic              hresp1;
  logic [DATA_W-1:0] hrdata0;
  logic [DATA_W-1:0] hrdata1;

  // Muxed HREADYOUT goes back to every slave as HREADY
  ahb_addr_decoder u_decoder (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HADDR      (HADDR),
    .HTRANS     (HTRANS),
    .HREADY     (HREADY),
    .hreadyout0 (hreadyout0),
    .hreadyout1 (hreadyout1),
    .hresp0     (hresp0),
    .hresp1     (hresp1),
    .hrdata0    (hrdata0),
    .hrdata1    (hrdata1),
    .hsel0      (hsel0),
    .hsel1      (hsel1),
    .hreadyout  (HREADY),
    .hresp      (HRESP),
    .hrdata     (HRDATA)
  );

  // Zero wait state reads
  ahb_sram_slave #(
    .MEM_DEPTH (MEM_DEPTH),
    .REG_OUT   (1'b0)
  ) u_sram0 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (hsel0),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (hrdata0),
    .HREADYOUT (hreadyout0),
    .HRESP     (hresp0)
  );

  // One wait state per read
  ahb_sram_slave #(
    .MEM_DEPTH (MEM_DEPTH),
    .REG_OUT   (1'b1)
  ) u_sram1 (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (hsel1),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (hrdata1),
    .HREADYOUT (hreadyout1),
    .HRESP     (hresp1)
  );

endmodule

//--- verification/ahb_sram_sva.sv
// Protocol assertions on the SRAM subsystem master port
// Two-cycle ERROR, ready IDLE data phase, OKAY for mapped regions

`timescale 1ns/1ns

module ahb_sram_sva (
  input logic                            HCLK,
  input logic                            HRESETn,
  input logic [ahb_lite_pkg::ADDR_W-1:0] HADDR,
  input logic [1:0]                      HTRANS,
  input logic                            HREADY,
  input logic                            HRESP
);

  import ahb_lite_pkg::*;

  logic addr_active;
  logic addr_mapped;

  // Address phase accepted on this edge
  assign addr_active = HREADY & ((HTRANS == HTRANS_NONSEQ) | (HTRANS == HTRANS_SEQ));
  assign addr_mapped = (HADDR[ADDR_W-1:REGION_BITS] == SLV0_BASE[ADDR_W-1:REGION_BITS]) |
                       (HADDR[ADDR_W-1:REGION_BITS] == SLV1_BASE[ADDR_W-1:REGION_BITS]);

  err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP == HRESP_ERROR) && !HREADY |=> (HRESP == HRESP_ERROR) && HREADY)
    else $error("ERROR response without a second cycle with HREADY high");

  // No wait states behind an IDLE
  idle_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    HREADY && (HTRANS == HTRANS_IDLE) |=> HREADY)
    else $error("HREADY low in the data phase of an IDLE transfer");

  mapped_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
    addr_active && addr_mapped |=> HRESP == HRESP_OKAY)
    else $error("HRESP not OKAY for a mapped address");

endmodule

bind ahb_sram_subsystem ahb_sram_sva ahb_sram_sva_i (
  .HCLK    (HCLK),
  .HRESETn (HRESETn),
  .HADDR   (HADDR),
  .HTRANS  (HTRANS),
  .HREADY  (HREADY),
  .HRESP   (HRESP)
);

//--- verification/tb_ahb_sram.sv
// Testbench for the AHB-Lite SRAM subsystem
// Stimulus table checked against a byte-lane reference memory
// Pipelined AHB-Lite master, compare tasks and cycle timeout

`timescale 1ns/1ns

module tb_ahb_sram;

  import ahb_lite_pkg::*;

  localparam int OP_IDLE     = 0;
  localparam int OP_WRITE    = 1;
  localparam int OP_READ     = 2;
  localparam int MAX_ENTRIES = 64;

  logic              HCLK;
  logic              HRESETn;
  logic [ADDR_W-1:0] HADDR;
  logic [1:0]        HTRANS;
  logic              HWRITE;
  logic [2:0]        HSIZE;
  logic [DATA_W-1:0] HWDATA;
  logic [DATA_W-1:0] HRDATA;
  logic              HREADY;
  logic              HRESP;

  // Stimulus table, one column per array
  int                t_op    [MAX_ENTRIES];
  logic [ADDR_W-1:0] t_addr  [MAX_ENTRIES];
  logic [2:0]        t_size  [MAX_ENTRIES];
  logic [DATA_W-1:0] t_wdata [MAX_ENTRIES];
  logic [DATA_W-1:0] t_rdata [MAX_ENTRIES];
  int                t_waits [MAX_ENTRIES];
  logic              t_resp  [MAX_ENTRIES];
  int                n_entries = 0;

  // Reference memory, one byte per bus address
  logic [7:0]        model_mem [logic [ADDR_W-1:0]];

  int cycle_count   = 0;
  int timeout_limit = 1000;

  ahb_sram_subsystem #(
    .MEM_DEPTH (256)
  ) ahb_sram_subsystem_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HADDR   (HADDR),
    .HTRANS  (HTRANS),
    .HWRITE  (HWRITE),
    .HSIZE   (HSIZE),
    .HWDATA  (HWDATA),
    .HRDATA  (HRDATA),
    .HREADY  (HREADY),
    .HRESP   (HRESP)
  );

  initial begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  always @(posedge HCLK) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("STATUS: FAIL");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic bit region_hit(input logic [ADDR_W-1:0] addr);
    return (addr[ADDR_W-1:REGION_BITS] == SLV0_BASE[ADDR_W-1:REGION_BITS]) ||
           (addr[ADDR_W-1:REGION_BITS] == SLV1_BASE[ADDR_W-1:REGION_BITS]);
  endfunction

  // Little endian, each byte rides on the lane of its address
  task automatic store_bytes(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                             input logic [DATA_W-1:0] wdata);
    int                nbytes;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] a;
    nbytes = 1 << size;
    // Transfers are aligned to their own size
    base   = addr & ~(ADDR_W'(nbytes) - 1);
    for (int k = 0; k < nbytes; k++) begin
      a            = base + ADDR_W'(k);
      model_mem[a] = wdata[8*a[1:0] +: 8];
    end
  endtask

  function automatic logic [DATA_W-1:0] load_word(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] word;
    logic [ADDR_W-1:0] base;
    base = {addr[ADDR_W-1:2], 2'b00};
    for (int k = 0; k < BE_W; k++) begin
      word[8*k +: 8] = model_mem[base + ADDR_W'(k)];
    end
    return word;
  endfunction

  // Expected read data comes from the model state at this point of the table
  task automatic add_entry(input int op, input logic [ADDR_W-1:0] addr,
                           input logic [2:0] size, input logic [DATA_W-1:0] wdata,
                           input int waits, input logic resp);
    t_op[n_entries]    = op;
    t_addr[n_entries]  = addr;
    t_size[n_entries]  = size;
    t_wdata[n_entries] = wdata;
    t_waits[n_entries] = waits;
    t_resp[n_entries]  = resp;
    t_rdata[n_entries] = '0;
    if (region_hit(addr) && op == OP_WRITE) begin
      store_bytes(addr, size, wdata);
    end else if (region_hit(addr) && op == OP_READ) begin
      t_rdata[n_entries] = load_word(addr);
    end
    n_entries++;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // op, address, size, write data, wait states, response
  task automatic build_table();
    // Word access to both regions
    add_entry(OP_WRITE, SLV0_BASE + 32'h000, HSIZE_WORD, 32'h1111_0000, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV1_BASE + 32'h000, HSIZE_WORD, 32'h2222_0001, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h004, HSIZE_WORD, 32'hA5A5_5A5A, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV1_BASE + 32'h004, HSIZE_WORD, 32'h0F0F_F0F0, 0, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h000, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_READ,  SLV1_BASE + 32'h000, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h004, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_READ,  SLV1_BASE + 32'h004, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
    // Byte lanes, other lanes of HWDATA carry noise
    add_entry(OP_WRITE, SLV0_BASE + 32'h010, HSIZE_WORD, 32'h0000_0000, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h010, HSIZE_BYTE, 32'h1122_33AB, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h011, HSIZE_BYTE, 32'h1122_CD44, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h012, HSIZE_BYTE, 32'h11EF_3344, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h013, HSIZE_BYTE, 32'h0122_3344, 0, HRESP_OKAY);
    add_entry(OP_IDLE,  SLV0_BASE + 32'h010, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h010, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    // Halfwords, then a read of the same word in slave 1
    add_entry(OP_WRITE, SLV1_BASE + 32'h020, HSIZE_WORD, 32'hFFFF_FFFF, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV1_BASE + 32'h020, HSIZE_HWORD, 32'h5555_1234, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV1_BASE + 32'h022, HSIZE_HWORD, 32'hBEEF_6666, 0, HRESP_OKAY);
    add_entry(OP_READ,  SLV1_BASE + 32'h020, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h018, HSIZE_WORD, 32'hFFFF_FFFF, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h01A, HSIZE_HWORD, 32'h0000_AAAA, 0, HRESP_OKAY);
    // Partial write then a read of another word, no stall
    add_entry(OP_READ,  SLV0_BASE + 32'h010, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV1_BASE + 32'h021, HSIZE_BYTE, 32'h0000_7700, 0, HRESP_OKAY);
    add_entry(OP_IDLE,  SLV1_BASE + 32'h000, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h018, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_READ,  SLV1_BASE + 32'h020, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
    // Read right behind a partial write stalls once in slave 0
    add_entry(OP_WRITE, SLV0_BASE + 32'h030, HSIZE_WORD, 32'h1234_5678, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h031, HSIZE_BYTE, 32'hFFFF_9AFF, 0, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h030, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
    // Full-word write is forwarded
    add_entry(OP_WRITE, SLV0_BASE + 32'h034, HSIZE_WORD, 32'h0BAD_F00D, 0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV0_BASE + 32'h034, HSIZE_WORD, 32'hCAFE_BABE, 0, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h034, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_WRITE, SLV1_BASE + 32'h034, HSIZE_WORD, 32'h8765_4321, 0, HRESP_OKAY);
    add_entry(OP_READ,  SLV1_BASE + 32'h034, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
    // Unmapped space, memory must stay as it was
    add_entry(OP_WRITE, 32'h0000_2000,       HSIZE_WORD, 32'hDEAD_BEEF, 1, HRESP_ERROR);
    add_entry(OP_READ,  32'h8000_0004,       HSIZE_WORD, 32'h0,         1, HRESP_ERROR);
    add_entry(OP_READ,  SLV0_BASE + 32'h000, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    // IDLE with HWRITE high writes nothing
    add_entry(OP_WRITE, SLV0_BASE + 32'h040, HSIZE_WORD, 32'h600D_CAFE, 0, HRESP_OKAY);
    add_entry(OP_IDLE,  SLV0_BASE + 32'h040, HSIZE_WORD, 32'hFFFF_FFFF, 0, HRESP_OKAY);
    add_entry(OP_IDLE,  SLV1_BASE + 32'h004, HSIZE_WORD, 32'hEEEE_EEEE, 0, HRESP_OKAY);
    add_entry(OP_READ,  SLV0_BASE + 32'h040, HSIZE_WORD, 32'h0,         0, HRESP_OKAY);
    add_entry(OP_READ,  SLV1_BASE + 32'h004, HSIZE_WORD, 32'h0,         1, HRESP_OKAY);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic fail_run(input int idx);
    $display("Failing table entry %0d", idx);
    $display("STATUS: FAIL");
    $fatal(1, "Check failed");
  endtask

  task automatic check_data(input int idx, input logic [DATA_W-1:0] actual,
                            input logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      $display("Mismatch HRDATA: got 0x%08h, expected 0x%08h", actual, expected);
      fail_run(idx);
    end
  endtask

  task automatic check_resp(input int idx, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Mismatch HRESP: got 0x%0h, expected 0x%0h", actual, expected);
      fail_run(idx);
    end
  endtask

  task automatic verify_wait_states(input int idx, input int actual, input int expected);
    if (actual != expected) begin
      $display("Mismatch HREADY wait states: got 0x%0h, expected 0x%0h", actual, expected);
      fail_run(idx);
    end
  endtask

  // Sample at the falling edge, where every DUT output has settled
  task automatic finish_data_phase(input int idx);
    int waits;
    bit done;
    waits = 0;
    done  = 1'b0;
    while (!done) begin
      @(negedge HCLK);
      if (idx >= 0) begin
        check_resp(idx, HRESP, t_resp[idx]);
      end
      if (HREADY) begin
        done = 1'b1;
      end else begin
        waits++;
      end
    end
    if (idx >= 0) begin
      verify_wait_states(idx, waits, t_waits[idx]);
      if (t_op[idx] == OP_READ && t_resp[idx] == HRESP_OKAY) begin
        check_data(idx, HRDATA, t_rdata[idx]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Master sequence
  //////////////////////////////////////////////////

  initial begin
    HRESETn = 1'b0;
    HADDR   = '0;
    HTRANS  = HTRANS_IDLE;
    HWRITE  = 1'b0;
    HSIZE   = HSIZE_WORD;
    HWDATA  = '0;
    build_table();
    timeout_limit = n_entries * 4 + 50;
    repeat (16) @(posedge HCLK);
    #5;
    HRESETn = 1'b1;
    // Address phase of entry i overlaps the data phase of entry i-1
    for (int i = 0; i <= n_entries; i++) begin
      if (i > 0) begin
        HWDATA = t_wdata[i-1];
      end
      if (i < n_entries) begin
        HADDR  = t_addr[i];
        HSIZE  = t_size[i];
        HWRITE = (t_op[i] != OP_READ);
        HTRANS = (t_op[i] == OP_IDLE) ? HTRANS_IDLE : HTRANS_NONSEQ;
      end else begin
        HTRANS = HTRANS_IDLE;
        HWRITE = 1'b0;
      end
      finish_data_phase(i - 1);
      @(posedge HCLK);
      #5;
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- src.f
hw/ahb_lite_pkg.sv
hw/ram_1r1w.sv
hw/ahb_sram_slave.sv
hw/ahb_addr_decoder.sv
hw/ahb_sram_subsystem.sv
verification/ahb_sram_sva.sv
verification/tb_ahb_sram.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AHB-Lite SRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ahb_sram -f src.f -o tb_ahb_sram
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_ahb_sram
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
